// File: rtl/timing_pkg.sv
`default_nettype none

package timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// Default screen geometry
	//////////////////////////////////////////////////////////////////////

	// Pixel slots per line at the 6 MHz pixel rate
	localparam int unsigned H_TOTAL_DEF = 384;
	// Visible pixels before horizontal blank
	localparam int unsigned H_ACTIVE_DEF = 288;
	// Horizontal sync window, end exclusive
	localparam int unsigned HSYNC_START_DEF = 320;
	localparam int unsigned HSYNC_END_DEF = 352;

	// Lines per frame
	localparam int unsigned V_TOTAL_DEF = 264;
	// Visible lines before vertical blank
	localparam int unsigned V_ACTIVE_DEF = 224;
	// Vertical sync window, end exclusive
	localparam int unsigned VSYNC_START_DEF = 240;
	localparam int unsigned VSYNC_END_DEF = 243;

	//////////////////////////////////////////////////////////////////////
	// Position words
	//////////////////////////////////////////////////////////////////////

	// Horizontal position
	// Count view for geometry compares
	// Tap view for the 1H/2H/4H board clocks
	typedef union packed {
		logic [8:0] count;
		struct packed {
			// 8H and up
			logic [5:0] upper;
			logic t4h;
			logic t2h;
			// Bit 0, toggles every pixel
			logic t1h;
		} taps;
	} h_pos_t;

	// Vertical line count
	typedef logic [8:0] v_pos_t;

endpackage

`default_nettype wire

// File: rtl/clk_enable_if.sv
`default_nettype none
`timescale 1ns/100ps

// Divided clock enables, all single-cycle pulses on clk_48m
interface clk_enable_if ();

	// Every second master cycle
	logic ce_24m;
	// Every fourth master cycle
	logic ce_12m;
	// Pixel rate, every eighth master cycle
	logic ce_6m;
	// Pixel rate pulse one master cycle later
	logic ce_6md;

	// Driven by the divider
	modport src (output ce_24m, ce_12m, ce_6m, ce_6md);

	// Read by counters and output stage
	modport dst (input ce_24m, ce_12m, ce_6m, ce_6md);

endinterface

`default_nettype wire

// File: rtl/video_timing_if.sv
`default_nettype none
`timescale 1ns/100ps

// Counter positions and raw decodes, counter to output stage
interface video_timing_if import timing_pkg::*; ();

	// Registered positions
	h_pos_t hpos;
	v_pos_t vpos;

	// Horizontal decodes of hpos
	logic hsync;
	logic hblank;
	// Last pixel slot of the line
	logic hreset;

	// Vertical decodes of vpos
	logic vsync;
	logic vblank;
	// Last line of the frame
	logic vreset;

	// Counter side
	modport src (
		output hpos, vpos,
		output hsync, hblank, hreset,
		output vsync, vblank, vreset
	);

	// Output stage side
	modport dst (
		input hpos, vpos,
		input hsync, hblank, hreset,
		input vsync, vblank, vreset
	);

endinterface

`default_nettype wire

// File: rtl/clock_divider.sv
`default_nettype none
`timescale 1ns/100ps

module clock_divider (
	input logic clk_48m,
	input logic rst,
	clk_enable_if.src ce
);

	//////////////////////////////////////////////////////////////////////
	// Phase counter
	//////////////////////////////////////////////////////////////////////

	// Eight master cycles per pixel
	logic [2:0] phase;
	// Pixel enable delayed one master cycle
	logic ce_6m_d;

	always_ff @(posedge clk_48m) begin
		if (rst) begin
			phase <= 3'd0;
		end else begin
			// Free running, wraps 7 -> 0
			phase <= phase + 3'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Enable decode
	//////////////////////////////////////////////////////////////////////

	// Nested enables, all high together on phase 7
	assign ce.ce_24m = phase[0];
	assign ce.ce_12m = (phase[1:0] == 2'd3);
	assign ce.ce_6m = (phase == 3'd7);

	// Delayed pixel phase for the S1H/S2H taps
	always_ff @(posedge clk_48m) begin
		if (rst) begin
			ce_6m_d <= 1'b0;
		end else begin
			ce_6m_d <= ce.ce_6m;
		end
	end

	assign ce.ce_6md = ce_6m_d;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Slower enables sit inside the faster ones
	a_nested_enables: assert property (
		@(posedge clk_48m) disable iff (rst)
		ce.ce_6m |-> (ce.ce_12m && ce.ce_24m)
	);

	// Delayed phase never overlaps its source
	a_6md_apart: assert property (
		@(posedge clk_48m) disable iff (rst)
		!(ce.ce_6m && ce.ce_6md)
	);

endmodule

`default_nettype wire

// File: rtl/video_counter.sv
`default_nettype none
`timescale 1ns/100ps

module video_counter import timing_pkg::*; #(
	parameter int unsigned h_total = H_TOTAL_DEF,
	parameter int unsigned h_active = H_ACTIVE_DEF,
	parameter int unsigned hsync_start = HSYNC_START_DEF,
	parameter int unsigned hsync_end = HSYNC_END_DEF,
	parameter int unsigned v_total = V_TOTAL_DEF,
	parameter int unsigned v_active = V_ACTIVE_DEF,
	parameter int unsigned vsync_start = VSYNC_START_DEF,
	parameter int unsigned vsync_end = VSYNC_END_DEF
) (
	input logic clk_48m,
	input logic rst,
	clk_enable_if.dst ce,
	video_timing_if.src vt
);

	//////////////////////////////////////////////////////////////////////
	// Geometry at counter width
	//////////////////////////////////////////////////////////////////////

	// Horizontal
	localparam logic [8:0] h_last = 9'(h_total - 1);
	localparam logic [8:0] h_act = 9'(h_active);
	localparam logic [8:0] hs_start = 9'(hsync_start);
	localparam logic [8:0] hs_end = 9'(hsync_end);

	// Vertical
	localparam logic [8:0] v_last = 9'(v_total - 1);
	localparam logic [8:0] v_act = 9'(v_active);
	localparam logic [8:0] vs_start = 9'(vsync_start);
	localparam logic [8:0] vs_end = 9'(vsync_end);

	//////////////////////////////////////////////////////////////////////
	// Pixel and line counters
	//////////////////////////////////////////////////////////////////////

	h_pos_t hpos;
	v_pos_t vpos;

	// End of line doubles as the hreset strobe
	logic h_wrap;
	// End of frame doubles as the vreset strobe
	logic v_wrap;

	assign h_wrap = (hpos.count == h_last);
	assign v_wrap = (vpos == v_last);

	always_ff @(posedge clk_48m) begin
		if (rst) begin
			hpos <= '0;
			vpos <= '0;
		end else if (ce.ce_6m) begin
			if (h_wrap) begin
				hpos.count <= 9'd0;
				// Line advances only at end of line
				if (v_wrap) begin
					vpos <= 9'd0;
				end else begin
					vpos <= vpos + 9'd1;
				end
			end else begin
				hpos.count <= hpos.count + 9'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decodes
	//////////////////////////////////////////////////////////////////////

	assign vt.hpos = hpos;
	assign vt.vpos = vpos;

	// Right border and retrace
	assign vt.hblank = (hpos.count >= h_act);
	// Sync window with exclusive end
	assign vt.hsync = (hpos.count >= hs_start) && (hpos.count < hs_end);
	assign vt.hreset = h_wrap;

	// Bottom border and retrace
	assign vt.vblank = (vpos >= v_act);
	assign vt.vsync = (vpos >= vs_start) && (vpos < vs_end);
	// Held for the whole last line
	assign vt.vreset = v_wrap;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Counters never run past the programmed totals
	a_hpos_range: assert property (
		@(posedge clk_48m) disable iff (rst)
		hpos.count <= h_last
	);

	a_vpos_range: assert property (
		@(posedge clk_48m) disable iff (rst)
		vpos <= v_last
	);

endmodule

`default_nettype wire

// File: rtl/video_sync_out.sv
`default_nettype none
`timescale 1ns/100ps

module video_sync_out (
	input logic clk_48m,
	input logic rst,
	clk_enable_if.dst ce,
	video_timing_if.dst vt,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank,
	output logic hreset,
	output logic vreset,
	output logic blanking,
	output logic compsync,
	output logic clk_1h,
	output logic clk_2h,
	output logic clk_4h,
	output logic clk_1v,
	output logic clk_4v,
	output logic clk_8v,
	output logic clk_s1h,
	output logic clk_s2h
);

	// 4H rises on the coming pixel step as the low bits go from 3 to 4
	logic blank_load;
	// S1H/S2H sampled on the delayed pixel phase
	logic s1h_q;
	logic s2h_q;

	assign blank_load = ce.ce_6m && vt.hpos.taps.t1h && vt.hpos.taps.t2h &&
		!vt.hpos.taps.t4h && !vt.hreset;

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			hreset <= 1'b0;
			vreset <= 1'b0;
			compsync <= 1'b0;
			clk_1h <= 1'b0;
			clk_2h <= 1'b0;
			clk_4h <= 1'b0;
			clk_1v <= 1'b0;
			clk_4v <= 1'b0;
			clk_8v <= 1'b0;
			clk_s1h <= 1'b0;
			clk_s2h <= 1'b0;
		end else begin
			hsync <= vt.hsync;
			vsync <= vt.vsync;
			hreset <= vt.hreset;
			vreset <= vt.vreset;
			// Active high composite of either sync
			compsync <= vt.hsync || vt.vsync;
			// Horizontal taps through the union's tap view
			clk_1h <= vt.hpos.taps.t1h;
			clk_2h <= vt.hpos.taps.t2h;
			clk_4h <= vt.hpos.taps.t4h;
			clk_1v <= vt.vpos[0];
			clk_4v <= vt.vpos[2];
			clk_8v <= vt.vpos[3];
			clk_s1h <= s1h_q;
			clk_s2h <= s2h_q;
		end
	end

	// Blank flags straight from the position decodes
	always_ff @(posedge clk_48m) begin
		hblank <= vt.hblank;
		vblank <= vt.vblank;
	end

	//////////////////////////////////////////////////////////////////////
	// Blanking latch and delayed taps
	//////////////////////////////////////////////////////////////////////

	// Vblank clear wins over the 4H load
	always_ff @(posedge clk_48m) begin
		if (vt.vblank) begin
			blanking <= 1'b1;
		end else if (rst || blank_load) begin
			blanking <= vt.hblank;
		end
	end

	// New pixel position is settled by the delayed phase
	always_ff @(posedge clk_48m) begin
		if (rst) begin
			s1h_q <= 1'b0;
			s2h_q <= 1'b0;
		end else if (ce.ce_6md) begin
			s1h_q <= vt.hpos.taps.t1h;
			s2h_q <= vt.hpos.taps.t2h;
		end
	end

	// End of line strobe lasts a single pixel
	a_hreset_single: assert property (
		@(posedge clk_48m) disable iff (rst)
		(ce.ce_6m && vt.hreset) |=> !vt.hreset
	);

endmodule

`default_nettype wire

// File: rtl/timing_subsystem.sv
`default_nettype none
`timescale 1ns/100ps

module timing_subsystem import timing_pkg::*; #(
	parameter int unsigned h_total = H_TOTAL_DEF,
	parameter int unsigned h_active = H_ACTIVE_DEF,
	parameter int unsigned hsync_start = HSYNC_START_DEF,
	parameter int unsigned hsync_end = HSYNC_END_DEF,
	parameter int unsigned v_total = V_TOTAL_DEF,
	parameter int unsigned v_active = V_ACTIVE_DEF,
	parameter int unsigned vsync_start = VSYNC_START_DEF,
	parameter int unsigned vsync_end = VSYNC_END_DEF
) (
	input logic clk_48m,
	input logic rst,
	output logic ce_6m,
	output logic ce_6md,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank,
	output logic hreset,
	output logic vreset,
	output logic blanking,
	output logic compsync,
	output logic clk_1h,
	output logic clk_2h,
	output logic clk_4h,
	output logic clk_1v,
	output logic clk_4v,
	output logic clk_8v,
	output logic clk_s1h,
	output logic clk_s2h
);

	//////////////////////////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////////////////////////

	clk_enable_if ce_bus ();
	video_timing_if vt_bus ();

	// Pixel enables for downstream video logic
	assign ce_6m = ce_bus.ce_6m;
	assign ce_6md = ce_bus.ce_6md;

	// Master clock divider
	clock_divider u_clock_divider (
		.clk_48m(clk_48m),
		.rst(rst),
		.ce(ce_bus)
	);

	// H/V counters and decodes
	video_counter #(
		.h_total(h_total),
		.h_active(h_active),
		.hsync_start(hsync_start),
		.hsync_end(hsync_end),
		.v_total(v_total),
		.v_active(v_active),
		.vsync_start(vsync_start),
		.vsync_end(vsync_end)
	) u_video_counter (
		.clk_48m(clk_48m),
		.rst(rst),
		.ce(ce_bus),
		.vt(vt_bus)
	);

	// Registered outputs, blanking latch, composite sync
	video_sync_out u_video_sync_out (
		.clk_48m(clk_48m),
		.rst(rst),
		.ce(ce_bus),
		.vt(vt_bus),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.hreset(hreset),
		.vreset(vreset),
		.blanking(blanking),
		.compsync(compsync),
		.clk_1h(clk_1h),
		.clk_2h(clk_2h),
		.clk_4h(clk_4h),
		.clk_1v(clk_1v),
		.clk_4v(clk_4v),
		.clk_8v(clk_8v),
		.clk_s1h(clk_s1h),
		.clk_s2h(clk_s2h)
	);

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

// Master clock and power-on reset for the testbench
module tb_clock_gen #(
	parameter real period_ns = 8.0,
	parameter int unsigned reset_cycles = 3
) (
	output logic clk,
	output logic rst
);

	// Free running master clock
	initial begin
		clk = 1'b0;
	end

	always #(period_ns / 2.0) clk = ~clk;

	// Reset held over a fixed number of rising edges, released just after one
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: verification/timing_subsystem_tb.sv
`default_nettype none
`timescale 1ns/100ps

module timing_subsystem_tb import timing_pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// Run lengths
	//////////////////////////////////////////////////////////////////////

	localparam real CLK_PERIOD = 8.0;
	// Master cycles per line and per frame
	localparam int unsigned LINE_CYCLES = H_TOTAL_DEF * 8;
	localparam int unsigned FRAME_CYCLES = LINE_CYCLES * V_TOTAL_DEF;
	// Three frames of master cycles
	localparam real WATCHDOG_NS = 3.0 * H_TOTAL_DEF * V_TOTAL_DEF * 8 * CLK_PERIOD;

	// Expected DUT outputs for one master cycle
	typedef struct packed {
		logic ce_6m;
		logic ce_6md;
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
		logic hreset;
		logic vreset;
		logic blanking;
		logic compsync;
		h_pos_t htaps;
		h_pos_t staps;
		logic clk_1v;
		logic clk_4v;
		logic clk_8v;
	} expect_t;

	logic clk_48m;
	logic por_rst;
	logic mid_rst;
	logic rst;
	logic ce_6m;
	logic ce_6md;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	logic hreset;
	logic vreset;
	logic blanking;
	logic compsync;
	logic clk_1h;
	logic clk_2h;
	logic clk_4h;
	logic clk_1v;
	logic clk_4v;
	logic clk_8v;
	logic clk_s1h;
	logic clk_s2h;

	// Model state
	int unsigned cycle = 0;
	int unsigned reset_edges = 0;
	logic blank_model = 1'b0;
	int unsigned cur_p;
	h_pos_t cur_pos;
	h_pos_t next_pos;
	expect_t exp_out;
	h_pos_t act_h;
	h_pos_t act_s;
	string test_name = "power_on";
	integer seed;
	int unsigned reset_offset;

	assign rst = por_rst | mid_rst;

	tb_clock_gen #(
		.period_ns(CLK_PERIOD),
		.reset_cycles(3)
	) u_clock_gen (
		.clk(clk_48m),
		.rst(por_rst)
	);

	timing_subsystem #(
		.h_total(H_TOTAL_DEF),
		.h_active(H_ACTIVE_DEF),
		.hsync_start(HSYNC_START_DEF),
		.hsync_end(HSYNC_END_DEF),
		.v_total(V_TOTAL_DEF),
		.v_active(V_ACTIVE_DEF),
		.vsync_start(VSYNC_START_DEF),
		.vsync_end(VSYNC_END_DEF)
	) dut (
		.clk_48m(clk_48m), .rst(rst),
		.ce_6m(ce_6m), .ce_6md(ce_6md),
		.hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank),
		.hreset(hreset), .vreset(vreset), .blanking(blanking), .compsync(compsync),
		.clk_1h(clk_1h), .clk_2h(clk_2h), .clk_4h(clk_4h),
		.clk_1v(clk_1v), .clk_4v(clk_4v), .clk_8v(clk_8v),
		.clk_s1h(clk_s1h), .clk_s2h(clk_s2h)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Pixel position after p pixel steps
	function automatic h_pos_t hpos_at(input int unsigned p);
		h_pos_t r;
		r.count = 9'(p % H_TOTAL_DEF);
		return r;
	endfunction

	// Line number after p pixel steps
	function automatic v_pos_t vpos_at(input int unsigned p);
		return 9'((p / H_TOTAL_DEF) % V_TOTAL_DEF);
	endfunction

	// Outputs for cycle k after reset release
	function automatic expect_t expected_outputs(input int unsigned k, input logic blank_state);
		expect_t e;
		int unsigned p;
		int unsigned ps;
		int unsigned h;
		int unsigned v;
		h_pos_t hs;
		v_pos_t vp;
		// Output register shows the position one cycle back
		p = (k == 0) ? 0 : (k - 1) / 8;
		// S taps go through one more register
		ps = (k < 2) ? 0 : (k - 2) / 8;
		h = p % H_TOTAL_DEF;
		v = (p / H_TOTAL_DEF) % V_TOTAL_DEF;
		hs = hpos_at(ps);
		vp = vpos_at(p);
		e = '0;
		// Pixel enable on phase 7 and its delayed copy on phase 0
		e.ce_6m = (k % 8 == 7);
		e.ce_6md = (k >= 8) && (k % 8 == 0);
		e.hsync = (h >= HSYNC_START_DEF) && (h < HSYNC_END_DEF);
		e.hblank = (h >= H_ACTIVE_DEF);
		e.hreset = (h == H_TOTAL_DEF - 1);
		e.vsync = (v >= VSYNC_START_DEF) && (v < VSYNC_END_DEF);
		e.vblank = (v >= V_ACTIVE_DEF);
		e.vreset = (v == V_TOTAL_DEF - 1);
		e.compsync = e.hsync || e.vsync;
		e.blanking = blank_state;
		// Only the three low tap bits leave the chip
		e.htaps = hpos_at(p);
		e.htaps.taps.upper = '0;
		e.staps.taps.t1h = hs.taps.t1h;
		e.staps.taps.t2h = hs.taps.t2h;
		e.clk_1v = vp[0];
		e.clk_4v = vp[2];
		e.clk_8v = vp[3];
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s %s cycle %0d: expected %b actual %b",
				test_name, sig, cycle, exp, act);
			abort_run();
		end
	endtask

	task automatic check_pos(input string sig, input h_pos_t exp, input h_pos_t act);
		if (act !== exp) begin
			$display("[FAIL] %s %s cycle %0d: expected %b actual %b",
				test_name, sig, cycle, exp, act);
			abort_run();
		end
	endtask

	// Cycle count and blanking latch model step on every master edge
	always @(posedge clk_48m) begin
		if (rst) begin
			cycle = 0;
			reset_edges = reset_edges + 1;
			// Latch loads from position 0 with the vblank clear first
			blank_model = (V_ACTIVE_DEF == 0) || (H_ACTIVE_DEF == 0);
		end else begin
			reset_edges = 0;
			cur_p = cycle / 8;
			cur_pos = hpos_at(cur_p);
			next_pos = hpos_at(cur_p + 1);
			if (vpos_at(cur_p) >= 9'(V_ACTIVE_DEF)) begin
				blank_model = 1'b1;
			end else if ((cycle % 8 == 7) && !cur_pos.taps.t4h && next_pos.taps.t4h) begin
				// 4H rising edge samples hblank of the old position
				blank_model = (cur_pos.count >= 9'(H_ACTIVE_DEF));
			end
			cycle = cycle + 1;
		end
	end

	// Mid-cycle compare once reset has flushed the registers
	always @(negedge clk_48m) begin
		if (!rst || reset_edges >= 2) begin
			exp_out = expected_outputs(cycle, blank_model);
			act_h = '0;
			act_h.taps.t1h = clk_1h;
			act_h.taps.t2h = clk_2h;
			act_h.taps.t4h = clk_4h;
			act_s = '0;
			act_s.taps.t1h = clk_s1h;
			act_s.taps.t2h = clk_s2h;
			check_bit("ce_6m", exp_out.ce_6m, ce_6m);
			check_bit("ce_6md", exp_out.ce_6md, ce_6md);
			check_bit("hsync", exp_out.hsync, hsync);
			check_bit("hblank", exp_out.hblank, hblank);
			check_bit("hreset", exp_out.hreset, hreset);
			check_bit("vsync", exp_out.vsync, vsync);
			check_bit("vblank", exp_out.vblank, vblank);
			check_bit("vreset", exp_out.vreset, vreset);
			check_bit("blanking", exp_out.blanking, blanking);
			check_bit("compsync", exp_out.compsync, compsync);
			check_pos("h_taps", exp_out.htaps, act_h);
			check_pos("s_taps", exp_out.staps, act_s);
			check_bit("clk_1v", exp_out.clk_1v, clk_1v);
			check_bit("clk_4v", exp_out.clk_4v, clk_4v);
			check_bit("clk_8v", exp_out.clk_8v, clk_8v);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and verdict
	//////////////////////////////////////////////////////////////////////

	initial begin
		mid_rst = 1'b0;
		seed = 76793;
		// Reset lands in the third frame after its first line
		reset_offset = LINE_CYCLES + ($unsigned($random(seed)) % (FRAME_CYCLES / 2));
		@(negedge por_rst);
		test_name = "first_line";
		repeat (LINE_CYCLES) @(posedge clk_48m);
		test_name = "two_frames";
		repeat (2 * FRAME_CYCLES - LINE_CYCLES + reset_offset) @(posedge clk_48m);
		#1 mid_rst = 1'b1;
		test_name = "mid_reset";
		repeat (3) @(posedge clk_48m);
		#1 mid_rst = 1'b0;
		// A few lines to see the timing restart from 0
		repeat (4 * LINE_CYCLES) @(posedge clk_48m);
		$display("TEST PASS");
		$finish;
	end

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the run did not end within three frames");
		abort_run();
	end

endmodule

`default_nettype wire

// File: filelist.f
rtl/timing_pkg.sv
rtl/clk_enable_if.sv
rtl/video_timing_if.sv
rtl/clock_divider.sv
rtl/video_counter.sv
rtl/video_sync_out.sv
rtl/timing_subsystem.sv
verification/tb_clock_gen.sv
verification/timing_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the video timing testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module timing_subsystem_tb \
	-f filelist.f \
	&& ./obj_dir/Vtiming_subsystem_tb | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
